// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = manycore_tile_tb
FILELIST = manycore_tile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run the testbench"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: manycore_tile.f
verilog/mesh_pkg.sv
verilog/mem_pkg.sv
verilog/packet_fifo.sv
verilog/xy_router.sv
verilog/banked_mem_xbar.sv
verilog/tile_ctrl.sv
verilog/manycore_tile.sv
verif/manycore_tile_tb.sv

// File: verif/manycore_tile_tb.sv
`timescale 1ns/1ps

module manycore_tile_tb;

  import mesh_pkg::*;
  import mem_pkg::*;

  localparam int         pkt_w_lp    = pkt_fixed_width_c + 10;
  localparam int         fifo_els_lp = 4;
  localparam logic [4:0] my_x_lp     = 5'd2;
  localparam logic [4:0] my_y_lp     = 5'd2;

  typedef logic [pkt_w_lp-1:0] pkt_t;
  typedef enum logic [3:0] {k_ctrl, k_nstore, k_pass, k_load, k_store, k_pair, k_ready} kind_t;

  // addr_b is the second port address, or {y, x} of a pass-through target
  typedef struct packed {
    kind_t       kind;
    logic [2:0]  port;
    word_t       addr;
    word_t       addr_b;
    logic [3:0]  mask;
    word_t       exp;
  } entry_t;

  logic                        clk_i;
  logic                        reset_i;
  logic [3:0][pkt_w_lp-1:0]    mesh_data;
  logic [3:0]                  mesh_valid;
  logic [3:0]                  mesh_yumi;
  logic [3:0]                  mesh_ready;
  logic [3:0][pkt_w_lp-1:0]    mesh_out;
  logic [3:0]                  mesh_v_out;
  logic [1:0]                  core_v;
  logic [1:0]                  core_w;
  logic [1:0][31:0]            core_addr;
  logic [1:0][31:0]            core_wdata;
  logic [1:0][3:0]             core_mask;
  logic [1:0]                  core_yumi_o;
  logic [1:0]                  core_rv_o;
  logic [1:0][31:0]            core_rdata_o;
  logic                        stall_o;

  entry_t tbl [$];
  pkt_t   exp_pkt_q [$];
  int     exp_dir_q [$];
  word_t  ref_mem [256];
  word_t  lcg_state = 32'd72;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  int     limit  = 100000;

  manycore_tile
    #(.bank_size_p (64)
     ,.num_banks_p (4)
     ,.fifo_els_p  (fifo_els_lp)
     ,.lg_node_x_p (5)
     ,.lg_node_y_p (5)
     ) dut0
    (.clk_i        (clk_i)
    ,.reset_i      (reset_i)
    ,.data_i       (mesh_data)
    ,.valid_i      (mesh_valid)
    ,.yumi_o       (mesh_yumi)
    ,.ready_i      (mesh_ready)
    ,.data_o       (mesh_out)
    ,.valid_o      (mesh_v_out)
    ,.my_x_i       (my_x_lp)
    ,.my_y_i       (my_y_lp)
    ,.core_v_i     (core_v)
    ,.core_w_i     (core_w)
    ,.core_addr_i  (core_addr)
    ,.core_wdata_i (core_wdata)
    ,.core_mask_i  (core_mask)
    ,.core_yumi_o  (core_yumi_o)
    ,.core_rv_o    (core_rv_o)
    ,.core_rdata_o (core_rdata_o)
    ,.stall_o      (stall_o)
    );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("Run stopped at the cycle limit of %0d", limit);
      $display("Something failed");
      $finish;
    end
  end

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic pkt_t make_pkt(input logic [5:0] op, input word_t a, input word_t d,
                                    input logic [4:0] y, input logic [4:0] x);
    return {op, a, d, y, x};
  endfunction

  function automatic word_t remote_addr(input logic [3:0] x, input logic [4:0] y,
                                        input logic [21:0] ofs);
    return {1'b1, x, y, ofs};
  endfunction

  function automatic word_t coord(input logic [4:0] y, input logic [4:0] x);
    return {22'b0, y, x};
  endfunction

  // x first, then y, seen from (2,2)
  function automatic int route_dir(input logic [4:0] x, input logic [4:0] y);
    if (x > my_x_lp)
      return dir_e_c;
    else if (x < my_x_lp)
      return dir_w_c;
    else if (y > my_y_lp)
      return dir_s_c;
    else if (y < my_y_lp)
      return dir_n_c;
    return dir_p_c;
  endfunction

  function automatic word_t byte_bits(input logic [3:0] m);
    word_t r;
    for (int k = 0; k < 4; k++)
      r[8*k +: 8] = {8{m[k]}};
    return r;
  endfunction

  // local stores go to the model, remote ones become expected mesh packets
  function automatic void record_store(input word_t a, input word_t d, input logic [3:0] m);
    if (a[31])
    begin
      exp_dir_q.push_back(route_dir({1'b0, a[30:27]}, a[26:22]));
      exp_pkt_q.push_back(make_pkt(op_store_c, {10'b0, a[21:0]}, d & byte_bits(m),
                                   a[26:22], {1'b0, a[30:27]}));
    end
    else
    begin
      for (int k = 0; k < 4; k++)
        if (m[k])
          ref_mem[a[9:2]][8*k +: 8] = d[8*k +: 8];
    end
  endfunction

  function automatic void add(input kind_t k, input int port, input word_t a, input word_t ab,
                              input logic [3:0] m, input word_t x);
    entry_t e;
    e.kind   = k;
    e.port   = 3'(port);
    e.addr   = a;
    e.addr_b = ab;
    e.mask   = m;
    e.exp    = x;
    tbl.push_back(e);
  endfunction

  function automatic void check_out(input int d, input pkt_t pkt);
    checks++;
    if (exp_pkt_q.size() == 0)
    begin
      $display("Unexpected packet left the tile on direction %0d", d);
      errors++;
    end
    else
    begin
      if (exp_dir_q[0] != d)
      begin
        $display("Fail valid_o direction expected %h got %h", exp_dir_q[0], d);
        errors++;
      end
      if (pkt !== exp_pkt_q[0])
      begin
        $display("Fail data_o[%0d] expected %h got %h", d, exp_pkt_q[0], pkt);
        errors++;
      end
      void'(exp_dir_q.pop_front());
      void'(exp_pkt_q.pop_front());
    end
  endfunction

  // mesh output monitor
  always @(negedge clk_i)
  begin
    if (!reset_i)
    begin
      for (int d = 0; d < 4; d++)
      begin
        if (mesh_v_out[d] && !mesh_ready[d])
        begin
          $display("Router drove valid on direction %0d while ready was low", d);
          errors++;
        end
        else if (mesh_v_out[d])
          check_out(d, mesh_out[d]);
      end
    end
  end

  task automatic mesh_send(input int p, input pkt_t pkt, input int pass_dir);
    int n;
    bit got;
    n = 0;
    got = 1'b0;
    @(posedge clk_i);
    mesh_data[p]  <= pkt;
    mesh_valid[p] <= 1'b1;
    while (!got && n < 20)
    begin
      @(negedge clk_i);
      got = mesh_yumi[p];
      // pass-through leaves in the cycle it is consumed
      if (got && pass_dir >= 0)
      begin
        checks++;
        if (!mesh_v_out[pass_dir] || mesh_out[pass_dir] !== pkt)
        begin
          $display("Fail data_o[%0d] expected %h got %h", pass_dir, pkt, mesh_out[pass_dir]);
          errors++;
        end
      end
      n++;
    end
    @(posedge clk_i);
    mesh_valid[p] <= 1'b0;
    if (!got)
    begin
      $display("Mesh input %0d never consumed its packet", p);
      errors++;
    end
  endtask

  task automatic wait_core_yumi(input int p, input int max_cycles, output bit got);
    int n;
    n = 0;
    got = 1'b0;
    while (!got && n < max_cycles)
    begin
      @(negedge clk_i);
      got = core_yumi_o[p];
      n++;
    end
  endtask

  task automatic wait_stall(input logic v);
    int n;
    n = 0;
    while (stall_o !== v && n < 10)
    begin
      @(negedge clk_i);
      n++;
    end
    checks++;
    if (stall_o !== v)
    begin
      $display("Fail stall_o expected %h got %h", v, stall_o);
      errors++;
    end
  endtask

  task automatic core_load(input int p, input word_t a);
    word_t exp_d;
    bit got;
    exp_d = ref_mem[a[9:2]];
    @(posedge clk_i);
    core_v[p]    <= 1'b1;
    core_w[p]    <= 1'b0;
    core_addr[p] <= a;
    wait_core_yumi(p, 20, got);
    @(posedge clk_i);
    core_v[p] <= 1'b0;
    checks++;
    if (!got)
    begin
      $display("Core port %0d load was never accepted", p);
      errors++;
    end
    else
    begin
      @(negedge clk_i);
      if (!core_rv_o[p])
      begin
        $display("Fail core_rv_o[%0d] expected %h got %h", p, 1'b1, core_rv_o[p]);
        errors++;
      end
      else if (core_rdata_o[p] !== exp_d)
      begin
        $display("Fail core_rdata_o[%0d] expected %h got %h", p, exp_d, core_rdata_o[p]);
        errors++;
      end
    end
  endtask

  task automatic core_store(input int p, input word_t a, input logic [3:0] m, input bit accept);
    word_t d;
    bit got;
    d = lcg_next();
    @(posedge clk_i);
    core_v[p]     <= 1'b1;
    core_w[p]     <= 1'b1;
    core_addr[p]  <= a;
    core_wdata[p] <= d;
    core_mask[p]  <= m;
    wait_core_yumi(p, accept ? 20 : 8, got);
    @(posedge clk_i);
    core_v[p] <= 1'b0;
    checks++;
    if (got != accept)
    begin
      $display("Core port %0d store was %s", p, accept ? "never accepted" : "accepted while full");
      errors++;
    end
    if (got)
      record_store(a, d, m);
  endtask

  // both ports store every cycle until each has count stores accepted
  task automatic core_pair(input word_t a0, input word_t a1, input logic [3:0] m, input int count);
    int         left [2];
    int         last_win;
    int         n;
    logic [1:0] yum;
    word_t      addr [2];
    word_t      d [2];
    addr[0]  = a0;
    addr[1]  = a1;
    last_win = -1;
    n        = 0;
    @(posedge clk_i);
    for (int i = 0; i < 2; i++)
    begin
      left[i]       = count;
      d[i]          = lcg_next();
      core_v[i]     <= 1'b1;
      core_w[i]     <= 1'b1;
      core_addr[i]  <= addr[i];
      core_wdata[i] <= d[i];
      core_mask[i]  <= m;
    end
    while ((left[0] > 0 || left[1] > 0) && n < 20 * count)
    begin
      @(negedge clk_i);
      yum = core_yumi_o & core_v;
      if (core_v == 2'b11 && a0[31] && a1[31] && yum != 2'b00)
      begin
        checks++;
        if (yum == 2'b11)
        begin
          $display("Both remote stores were accepted in one cycle");
          errors++;
        end
        else if (last_win >= 0 && yum[last_win])
        begin
          $display("Arbiter granted core port %0d twice in a row", last_win);
          errors++;
        end
        last_win = yum[1] ? 1 : 0;
      end
      for (int i = 0; i < 2; i++)
      begin
        if (yum[i])
        begin
          record_store(addr[i], d[i], m);
          left[i]--;
        end
      end
      @(posedge clk_i);
      for (int i = 0; i < 2; i++)
      begin
        if (yum[i] && left[i] > 0)
        begin
          d[i]          = lcg_next();
          core_wdata[i] <= d[i];
        end
        else if (yum[i])
          core_v[i] <= 1'b0;
      end
      n++;
    end
    if (left[0] > 0 || left[1] > 0)
    begin
      $display("Paired core stores were not all accepted");
      errors++;
      core_v <= 2'b00;
    end
  endtask

  task automatic apply_entry(input entry_t e);
    word_t d;
    pkt_t  pkt;
    case (e.kind)
      k_ctrl:
      begin
        mesh_send(e.port, make_pkt(op_ctrl_c, e.addr, '0, my_y_lp, my_x_lp), -1);
        wait_stall(e.exp[0]);
      end
      k_nstore:
      begin
        d = lcg_next();
        record_store(e.addr, d, 4'hf);
        mesh_send(e.port, make_pkt(op_store_c, e.addr, d, my_y_lp, my_x_lp), -1);
        // let the packet reach memory
        repeat (3) @(posedge clk_i);
      end
      k_pass:
      begin
        pkt = make_pkt(op_store_c, '0, lcg_next(), e.addr_b[9:5], e.addr_b[4:0]);
        exp_dir_q.push_back(int'(e.exp));
        exp_pkt_q.push_back(pkt);
        mesh_send(e.port, pkt, int'(e.exp));
      end
      k_load:
        core_load(e.port, e.addr);
      k_store:
        core_store(e.port, e.addr, e.mask, e.exp[0]);
      k_pair:
        core_pair(e.addr, e.addr_b, e.mask, int'(e.exp));
      default:
      begin
        @(posedge clk_i);
        mesh_ready[e.port] <= e.exp[0];
      end
    endcase
  endtask

  task automatic build_table();
    // stall flag
    add(k_ctrl, dir_w_c, 32'h0, '0, 4'h0, 32'd0);
    add(k_ctrl, dir_w_c, 32'h1, '0, 4'h0, 32'd1);
    // network stores, then loads
    add(k_nstore, dir_w_c, 32'h00, '0, 4'hf, '0);
    add(k_nstore, dir_n_c, 32'h04, '0, 4'hf, '0);
    add(k_nstore, dir_e_c, 32'h08, '0, 4'hf, '0);
    add(k_nstore, dir_s_c, 32'h0c, '0, 4'hf, '0);
    add(k_nstore, dir_w_c, 32'h10, '0, 4'hf, '0);
    add(k_nstore, dir_w_c, 32'h18, '0, 4'hf, '0);
    for (int i = 0; i < 5; i++)
      add(k_load, 0, 32'(4 * i), '0, 4'h0, '0);
    add(k_load, 0, 32'h18, '0, 4'h0, '0);
    // local masked stores, same bank pairs included
    add(k_store, 0, 32'h00, '0, 4'b0011, 32'd1);
    add(k_store, 1, 32'h04, '0, 4'b1100, 32'd1);
    add(k_pair, 0, 32'h08, 32'h18, 4'b0101, 32'd1);
    add(k_pair, 0, 32'h10, 32'h10, 4'b0110, 32'd1);
    add(k_pair, 0, 32'h0c, 32'h00, 4'b1001, 32'd1);
    add(k_load, 1, 32'h00, '0, 4'h0, '0);
    add(k_load, 0, 32'h04, '0, 4'h0, '0);
    add(k_load, 1, 32'h08, '0, 4'h0, '0);
    add(k_load, 0, 32'h18, '0, 4'h0, '0);
    add(k_load, 1, 32'h10, '0, 4'h0, '0);
    add(k_load, 1, 32'h0c, '0, 4'h0, '0);
    // pass-through
    add(k_pass, dir_w_c, '0, coord(5'd2, 5'd3), 4'h0, dir_e_c);
    add(k_pass, dir_w_c, '0, coord(5'd1, 5'd2), 4'h0, dir_n_c);
    add(k_pass, dir_s_c, '0, coord(5'd2, 5'd0), 4'h0, dir_w_c);
    // remote stores in each direction
    add(k_store, 0, remote_addr(4'd5, 5'd2, 22'h100), '0, 4'b1111, 32'd1);
    add(k_store, 1, remote_addr(4'd1, 5'd7, 22'h024), '0, 4'b0110, 32'd1);
    add(k_store, 0, remote_addr(4'd2, 5'd0, 22'h008), '0, 4'b1001, 32'd1);
    add(k_store, 1, remote_addr(4'd2, 5'd9, 22'h3fc), '0, 4'b1110, 32'd1);
    // east held off until the outbound fifo fills
    add(k_ready, dir_e_c, '0, '0, 4'h0, 32'd0);
    for (int i = 0; i < fifo_els_lp; i++)
      add(k_store, 0, remote_addr(4'd3, 5'd2, 22'(4 * i)), '0, 4'(4'hf >> (i % 2)), 32'd1);
    add(k_store, 1, remote_addr(4'd3, 5'd2, 22'h40), '0, 4'hf, 32'd0);
    add(k_load, 0, 32'h00, '0, 4'h0, '0);
    add(k_ready, dir_e_c, '0, '0, 4'h0, 32'd1);
    // fairness burst
    add(k_pair, 0, remote_addr(4'd4, 5'd2, 22'h40), remote_addr(4'd4, 5'd3, 22'h80),
        4'hf, 32'd6);
  endtask

  initial
  begin
    int n;
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    mesh_data  = '0;
    mesh_valid = '0;
    mesh_ready = 4'hf;
    core_v     = '0;
    core_w     = '0;
    core_addr  = '0;
    core_wdata = '0;
    core_mask  = '0;
    build_table();
    limit = 16 + tbl.size() * 40;
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    checks++;
    if (stall_o !== 1'b1)
    begin
      $display("Fail stall_o expected %h got %h", 1'b1, stall_o);
      errors++;
    end
    if (mesh_v_out !== 4'h0 || core_yumi_o !== 2'b00 || core_rv_o !== 2'b00)
    begin
      $display("Fail valid_o/core_yumi_o/core_rv_o expected %h got %h", 8'h00,
               {mesh_v_out, core_yumi_o, core_rv_o});
      errors++;
    end
    foreach (tbl[i])
      apply_entry(tbl[i]);
    n = 0;
    while (exp_pkt_q.size() > 0 && n < 50)
    begin
      @(posedge clk_i);
      n++;
    end
    if (exp_pkt_q.size() > 0)
    begin
      $display("%0d expected packets never left the tile", exp_pkt_q.size());
      errors++;
    end
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: verilog/banked_mem_xbar.sv
`timescale 1ns/1ps

module banked_mem_xbar
  #(parameter  int num_banks_p  = 4
   ,parameter  int bank_size_p  = 64
   ,localparam int lg_banks_lp  = $clog2(num_banks_p)
   ,localparam int lg_rows_lp   = $clog2(bank_size_p)
   ,localparam int idx_width_lp = lg_banks_lp + lg_rows_lp
  )
  (input                                 clk_i
  ,input                                 reset_i
  ,input        [2:0]                    v_i
  ,input        [2:0]                    w_i
  ,input        [2:0][idx_width_lp-1:0]  addr_i
  ,input        mem_pkg::word_t [2:0]    data_i
  ,input        mem_pkg::mask_t [2:0]    mask_i
  ,output logic [2:0]                    yumi_o
  ,output logic [2:0]                    v_o
  ,output       mem_pkg::word_t [2:0]    data_o
  );

  import mem_pkg::*;

  localparam int bytes_lp = $bits(mask_t);

  logic  [2:0][lg_banks_lp-1:0] bank;
  logic  [2:0][lg_rows_lp-1:0]  row;
  logic  [2:0]                  rd_v_r;
  logic  [2:0][lg_banks_lp-1:0] rd_bank_r;
  word_t                        bank_rdata_r [num_banks_p];

  for (genvar p = 0; p < 3; p++)
  begin : g_port
    assign bank[p]   = addr_i[p][lg_banks_lp-1:0];
    assign row[p]    = addr_i[p][idx_width_lp-1:lg_banks_lp];
    assign data_o[p] = bank_rdata_r[rd_bank_r[p]];
  end

  // on a bank conflict port 2 wins, then port 0, then port 1
  assign yumi_o[2] = v_i[2];
  assign yumi_o[0] = v_i[0] & ~(v_i[2] & (bank[2] == bank[0]));
  assign yumi_o[1] = v_i[1] & ~(v_i[2] & (bank[2] == bank[1]))
                            & ~(v_i[0] & (bank[0] == bank[1]));

  for (genvar b = 0; b < num_banks_p; b++)
  begin : g_bank
    word_t      mem_r [bank_size_p];
    logic       sel_v;
    logic [1:0] sel;

    // at most one granted port maps onto this bank
    always_comb
    begin
      sel_v = 1'b0;
      sel   = 2'd0;
      for (int p = 0; p < 3; p++)
      begin
        if (yumi_o[p] && bank[p] == lg_banks_lp'(b))
        begin
          sel_v = 1'b1;
          sel   = 2'(p);
        end
      end
    end

    always_ff @(posedge clk_i)
    begin
      if (sel_v)
      begin
        if (w_i[sel])
        begin
          for (int k = 0; k < bytes_lp; k++)
            if (mask_i[sel][k])
              mem_r[row[sel]][8*k +: 8] <= data_i[sel][8*k +: 8];
        end
        else
          bank_rdata_r[b] <= mem_r[row[sel]];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rd_v_r <= '0;
    else
      rd_v_r <= yumi_o & ~w_i;
  end

  always_ff @(posedge clk_i)
  begin
    rd_bank_r <= bank;
  end

  assign v_o = rd_v_r;

  // a request that loses a bank conflict waits on its port unchanged
  for (genvar p = 0; p < 3; p++)
  begin : g_chk
    assert property (@(posedge clk_i) disable iff (reset_i)
                     v_i[p] && !yumi_o[p] |=> v_i[p] && $stable(addr_i[p]))
      else $error("banked_mem_xbar: port %0d dropped a request before its grant", p);
  end

endmodule

// File: verilog/manycore_tile.sv
`timescale 1ns/1ps

module manycore_tile
  #(parameter  int bank_size_p     = 64
   ,parameter  int num_banks_p     = 4
   ,parameter  int fifo_els_p      = 4
   ,parameter  int lg_node_x_p     = 5
   ,parameter  int lg_node_y_p     = 5
   ,localparam int dirs_lp         = mesh_pkg::num_dirs_c
   ,localparam int packet_width_lp = mesh_pkg::pkt_fixed_width_c + lg_node_x_p + lg_node_y_p
  )
  (input                                            clk_i
  ,input                                            reset_i
  ,input        [dirs_lp-1:0][packet_width_lp-1:0] data_i
  ,input        [dirs_lp-1:0]                      valid_i
  ,output logic [dirs_lp-1:0]                      yumi_o
  ,input        [dirs_lp-1:0]                      ready_i
  ,output logic [dirs_lp-1:0][packet_width_lp-1:0] data_o
  ,output logic [dirs_lp-1:0]                      valid_o
  ,input        [lg_node_x_p-1:0]                  my_x_i
  ,input        [lg_node_y_p-1:0]                  my_y_i
  ,input        [1:0]                              core_v_i
  ,input        [1:0]                              core_w_i
  ,input        mem_pkg::addr_t [1:0]              core_addr_i
  ,input        mem_pkg::word_t [1:0]              core_wdata_i
  ,input        mem_pkg::mask_t [1:0]              core_mask_i
  ,output logic [1:0]                              core_yumi_o
  ,output logic [1:0]                              core_rv_o
  ,output       mem_pkg::word_t [1:0]              core_rdata_o
  ,output logic                                    stall_o
  );

  import mesh_pkg::*;
  import mem_pkg::*;

  localparam int mem_idx_width_lp = $clog2(num_banks_p) + $clog2(bank_size_p);

  // router side, index dir_p_c is the tile itself
  logic [dirs_lp:0][packet_width_lp-1:0] rtr_data_in;
  logic [dirs_lp:0][packet_width_lp-1:0] rtr_data_out;
  logic [dirs_lp:0]                      rtr_v_in;
  logic [dirs_lp:0]                      rtr_yumi;
  logic [dirs_lp:0]                      rtr_ready;
  logic [dirs_lp:0]                      rtr_v_out;

  logic [packet_width_lp-1:0]        in_pkt;
  logic                              in_v;
  logic                              in_yumi;
  logic [packet_width_lp-1:0]        out_pkt;
  logic                              out_v;
  logic                              out_ready;

  logic  [2:0]                       mem_v;
  logic  [2:0]                       mem_w;
  logic  [2:0][mem_idx_width_lp-1:0] mem_addr;
  word_t [2:0]                       mem_data;
  mask_t [2:0]                       mem_mask;
  logic  [2:0]                       mem_yumi;
  logic  [2:0]                       mem_rv;
  word_t [2:0]                       mem_rdata;

  assign rtr_data_in[dirs_lp-1:0] = data_i;
  assign rtr_v_in[dirs_lp-1:0]    = valid_i;
  assign rtr_ready[dirs_lp-1:0]   = ready_i;
  assign yumi_o                   = rtr_yumi[dirs_lp-1:0];
  assign data_o                   = rtr_data_out[dirs_lp-1:0];
  assign valid_o                  = rtr_v_out[dirs_lp-1:0];

  assign core_rv_o    = mem_rv[1:0];
  assign core_rdata_o = mem_rdata[1:0];

  xy_router #(.lg_node_x_p(lg_node_x_p), .lg_node_y_p(lg_node_y_p)) router0
    (.clk_i   (clk_i)
    ,.reset_i (reset_i)
    ,.data_i  (rtr_data_in)
    ,.valid_i (rtr_v_in)
    ,.yumi_o  (rtr_yumi)
    ,.ready_i (rtr_ready)
    ,.data_o  (rtr_data_out)
    ,.valid_o (rtr_v_out)
    ,.my_x_i  (my_x_i)
    ,.my_y_i  (my_y_i)
    );

  packet_fifo #(.width_p(packet_width_lp), .els_p(fifo_els_p)) fifo_net_to_mem
    (.clk_i   (clk_i)
    ,.reset_i (reset_i)
    ,.data_i  (rtr_data_out[dir_p_c])
    ,.v_i     (rtr_v_out[dir_p_c])
    ,.ready_o (rtr_ready[dir_p_c])
    ,.v_o     (in_v)
    ,.data_o  (in_pkt)
    ,.yumi_i  (in_yumi)
    );

  packet_fifo #(.width_p(packet_width_lp), .els_p(fifo_els_p)) fifo_mem_to_net
    (.clk_i   (clk_i)
    ,.reset_i (reset_i)
    ,.data_i  (out_pkt)
    ,.v_i     (out_v)
    ,.ready_o (out_ready)
    ,.v_o     (rtr_v_in[dir_p_c])
    ,.data_o  (rtr_data_in[dir_p_c])
    ,.yumi_i  (rtr_yumi[dir_p_c])
    );

  banked_mem_xbar #(.num_banks_p(num_banks_p), .bank_size_p(bank_size_p)) xbar0
    (.clk_i   (clk_i)
    ,.reset_i (reset_i)
    ,.v_i     (mem_v)
    ,.w_i     (mem_w)
    ,.addr_i  (mem_addr)
    ,.data_i  (mem_data)
    ,.mask_i  (mem_mask)
    ,.yumi_o  (mem_yumi)
    ,.v_o     (mem_rv)
    ,.data_o  (mem_rdata)
    );

  tile_ctrl
    #(.lg_node_x_p     (lg_node_x_p)
     ,.lg_node_y_p     (lg_node_y_p)
     ,.mem_idx_width_p (mem_idx_width_lp)
     ) ctrl0
    (.clk_i        (clk_i)
    ,.reset_i      (reset_i)
    ,.core_v_i     (core_v_i)
    ,.core_w_i     (core_w_i)
    ,.core_addr_i  (core_addr_i)
    ,.core_wdata_i (core_wdata_i)
    ,.core_mask_i  (core_mask_i)
    ,.core_yumi_o  (core_yumi_o)
    ,.mem_v_o      (mem_v)
    ,.mem_w_o      (mem_w)
    ,.mem_addr_o   (mem_addr)
    ,.mem_data_o   (mem_data)
    ,.mem_mask_o   (mem_mask)
    ,.mem_yumi_i   (mem_yumi)
    ,.in_pkt_i     (in_pkt)
    ,.in_v_i       (in_v)
    ,.in_yumi_o    (in_yumi)
    ,.out_pkt_o    (out_pkt)
    ,.out_v_o      (out_v)
    ,.out_ready_i  (out_ready)
    ,.stall_o      (stall_o)
    );

endmodule

// File: verilog/mem_pkg.sv
package mem_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  // byte enables, active high
  typedef logic [3:0]  mask_t;

  // set for an address on another tile
  localparam int remote_bit_c = 31;

  // remote map: x in [30:27], y from bit 26 down, offset below y
  localparam int x_hi_c    = 30;
  localparam int x_width_c = 4;
  localparam int y_hi_c    = 26;

  // byte address to word index
  localparam int word_lsb_c = 2;

endpackage

// File: verilog/mesh_pkg.sv
package mesh_pkg;

  // op field of a mesh packet
  localparam int op_width_c = 6;
  typedef logic [op_width_c-1:0] op_t;

  // write data into the local memory of the destination tile
  localparam op_t op_store_c = 6'd1;
  // addr bit 0 loads the stall flag
  localparam op_t op_ctrl_c  = 6'd2;

  // packet is op, addr, data, y, x from msb down
  localparam int addr_width_c      = 32;
  localparam int data_width_c      = 32;
  localparam int pkt_fixed_width_c = op_width_c + addr_width_c + data_width_c;

  // field offsets above the y and x coordinates
  localparam int data_ofs_c = 0;
  localparam int addr_ofs_c = data_width_c;
  localparam int op_ofs_c   = data_width_c + addr_width_c;

  // router port indices
  localparam int dir_w_c    = 0;
  localparam int dir_e_c    = 1;
  localparam int dir_n_c    = 2;
  localparam int dir_s_c    = 3;
  localparam int dir_p_c    = 4;
  localparam int num_dirs_c = 4;

endpackage

// File: verilog/packet_fifo.sv
`timescale 1ns/1ps

module packet_fifo
  #(parameter  int width_p      = 8
   ,parameter  int els_p        = 4
   ,localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
  )
  (input                      clk_i
  ,input                      reset_i
  ,input        [width_p-1:0] data_i
  ,input                      v_i
  ,output logic               ready_o
  ,output logic               v_o
  ,output logic [width_p-1:0] data_o
  ,input                      yumi_i
  );

  logic [width_p-1:0]      mem_r [els_p];
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic                    full_r;
  logic                    enq;

  function automatic logic [ptr_width_lp-1:0] bump(input logic [ptr_width_lp-1:0] p);
    return (p == ptr_width_lp'(els_p - 1)) ? '0 : p + 1'b1;
  endfunction

  assign enq     = v_i & ready_o;
  assign ready_o = ~full_r;
  // equal pointers mean empty unless full is set
  assign v_o     = full_r | (rd_ptr_r != wr_ptr_r);
  assign data_o  = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      full_r   <= 1'b0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= bump(wr_ptr_r);
      if (yumi_i)
        rd_ptr_r <= bump(rd_ptr_r);
      if (enq != yumi_i)
        full_r <= enq & (bump(wr_ptr_r) == rd_ptr_r);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

  assert property (@(posedge clk_i) disable iff (reset_i) v_i |-> ~full_r)
    else $error("packet_fifo: write while full");

  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o)
    else $error("packet_fifo: yumi with no valid entry");

endmodule

// File: verilog/tile_ctrl.sv
`timescale 1ns/1ps

module tile_ctrl
  #(parameter  int lg_node_x_p     = 5
   ,parameter  int lg_node_y_p     = 5
   ,parameter  int mem_idx_width_p = 8
   ,localparam int packet_width_lp = mesh_pkg::pkt_fixed_width_c + lg_node_x_p + lg_node_y_p
  )
  (input                                      clk_i
  ,input                                      reset_i
  ,input        [1:0]                         core_v_i
  ,input        [1:0]                         core_w_i
  ,input        mem_pkg::addr_t [1:0]         core_addr_i
  ,input        mem_pkg::word_t [1:0]         core_wdata_i
  ,input        mem_pkg::mask_t [1:0]         core_mask_i
  ,output logic [1:0]                         core_yumi_o
  ,output logic [2:0]                         mem_v_o
  ,output logic [2:0]                         mem_w_o
  ,output logic [2:0][mem_idx_width_p-1:0]    mem_addr_o
  ,output       mem_pkg::word_t [2:0]         mem_data_o
  ,output       mem_pkg::mask_t [2:0]         mem_mask_o
  ,input        [2:0]                         mem_yumi_i
  ,input        [packet_width_lp-1:0]         in_pkt_i
  ,input                                      in_v_i
  ,output logic                               in_yumi_o
  ,output logic [packet_width_lp-1:0]         out_pkt_o
  ,output logic                               out_v_o
  ,input                                      out_ready_i
  ,output logic                               stall_o
  );

  import mesh_pkg::*;
  import mem_pkg::*;

  localparam int coord_width_lp = lg_node_x_p + lg_node_y_p;

  op_t        in_op;
  addr_t      in_addr;
  word_t      in_data;
  logic       in_store;
  logic [1:0] remote;
  logic [1:0] local_v;
  logic [1:0] rem_req;
  logic [1:0] rem_grant;
  logic       rem_sel;
  logic       last_r;
  addr_t      rem_addr;
  word_t      byte_en;
  mask_t      rem_mask;

  // packets from the network
  assign in_op    = in_pkt_i[coord_width_lp + op_ofs_c +: op_width_c];
  assign in_addr  = in_pkt_i[coord_width_lp + addr_ofs_c +: addr_width_c];
  assign in_data  = in_pkt_i[coord_width_lp + data_ofs_c +: data_width_c];
  assign in_store = in_v_i & (in_op == op_store_c);

  // stores wait for the crossbar, anything else is popped at once
  assign in_yumi_o = in_store ? mem_yumi_i[2] : in_v_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      stall_o <= 1'b1;
    else if (in_v_i && in_op == op_ctrl_c)
      stall_o <= in_addr[0];
  end

  for (genvar i = 0; i < 2; i++)
  begin : g_core
    assign remote[i]     = core_addr_i[i][remote_bit_c];
    assign local_v[i]    = core_v_i[i] & ~remote[i];
    assign rem_req[i]    = core_v_i[i] & core_w_i[i] & remote[i];
    assign mem_addr_o[i] = core_addr_i[i][word_lsb_c +: mem_idx_width_p];
  end

  // port 2 carries the network store with the full word enabled
  assign mem_v_o       = {in_store, local_v};
  assign mem_w_o       = {1'b1, core_w_i};
  assign mem_addr_o[2] = in_addr[word_lsb_c +: mem_idx_width_p];
  assign mem_data_o    = {in_data, core_wdata_i};
  assign mem_mask_o    = {mask_t'('1), core_mask_i};

  // round robin, the port that lost last time goes first
  always_comb
  begin
    if (rem_req == 2'b11)
      rem_grant = last_r ? 2'b01 : 2'b10;
    else
      rem_grant = rem_req;
  end

  assign rem_sel = rem_grant[1];
  assign out_v_o = (|rem_grant) & out_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      last_r <= 1'b1;
    else if (out_v_o)
      last_r <= rem_sel;
  end

  assign rem_addr = core_addr_i[rem_sel];
  assign rem_mask = core_mask_i[rem_sel];

  for (genvar k = 0; k < $bits(mask_t); k++)
  begin : g_byte
    assign byte_en[8*k +: 8] = {8{rem_mask[k]}};
  end

  assign out_pkt_o = {op_store_c
                     ,addr_t'(rem_addr[y_hi_c-lg_node_y_p:0])
                     ,core_wdata_i[rem_sel] & byte_en
                     ,rem_addr[y_hi_c -: lg_node_y_p]
                     ,lg_node_x_p'(rem_addr[x_hi_c -: x_width_c])
                     };

  assign core_yumi_o = (rem_grant & {2{out_ready_i}}) | (local_v & mem_yumi_i[1:0]);

  assert property (@(posedge clk_i) disable iff (reset_i)
                   (core_v_i & ~core_w_i & remote) == 2'b00)
    else $error("tile_ctrl: core issued a remote load");

endmodule

// File: verilog/xy_router.sv
`timescale 1ns/1ps

module xy_router
  #(parameter  int lg_node_x_p     = 5
   ,parameter  int lg_node_y_p     = 5
   ,localparam int ports_lp        = mesh_pkg::num_dirs_c + 1
   ,localparam int packet_width_lp = mesh_pkg::pkt_fixed_width_c + lg_node_x_p + lg_node_y_p
  )
  (input                                             clk_i
  ,input                                             reset_i
  ,input        [ports_lp-1:0][packet_width_lp-1:0] data_i
  ,input        [ports_lp-1:0]                      valid_i
  ,output logic [ports_lp-1:0]                      yumi_o
  ,input        [ports_lp-1:0]                      ready_i
  ,output logic [ports_lp-1:0][packet_width_lp-1:0] data_o
  ,output logic [ports_lp-1:0]                      valid_o
  ,input        [lg_node_x_p-1:0]                   my_x_i
  ,input        [lg_node_y_p-1:0]                   my_y_i
  );

  import mesh_pkg::*;

  localparam int dir_width_lp = $clog2(ports_lp);

  logic [dir_width_lp-1:0] out_dir [ports_lp];

  // x first, then y
  for (genvar i = 0; i < ports_lp; i++)
  begin : g_route
    logic [lg_node_x_p-1:0] dst_x;
    logic [lg_node_y_p-1:0] dst_y;

    assign dst_x = data_i[i][lg_node_x_p-1:0];
    assign dst_y = data_i[i][lg_node_x_p +: lg_node_y_p];

    assign out_dir[i] = (dst_x > my_x_i) ? dir_width_lp'(dir_e_c)
                      : (dst_x < my_x_i) ? dir_width_lp'(dir_w_c)
                      : (dst_y > my_y_i) ? dir_width_lp'(dir_s_c)
                      : (dst_y < my_y_i) ? dir_width_lp'(dir_n_c)
                      : dir_width_lp'(dir_p_c);
  end

  // lowest requesting input wins each ready output
  always_comb
  begin
    logic taken;
    yumi_o  = '0;
    valid_o = '0;
    data_o  = '0;
    for (int o = 0; o < ports_lp; o++)
    begin
      taken = 1'b0;
      for (int i = 0; i < ports_lp; i++)
      begin
        if (!taken && ready_i[o] && valid_i[i] && out_dir[i] == dir_width_lp'(o))
        begin
          taken     = 1'b1;
          yumi_o[i] = 1'b1;
          data_o[o] = data_i[i];
        end
      end
      valid_o[o] = taken;
    end
  end

  // no buffering here, so a packet not yet consumed must stay on its input
  for (genvar i = 0; i < ports_lp; i++)
  begin : g_chk
    assert property (@(posedge clk_i) disable iff (reset_i)
                     valid_i[i] && !yumi_o[i] |=> valid_i[i] && $stable(data_i[i]))
      else $error("xy_router: input %0d dropped its packet before it was consumed", i);
  end

endmodule
